// File: include/arcade_cfg.svh
`ifndef ARCADE_CFG_SVH
`define ARCADE_CFG_SVH

// host status word, loaded one byte at a time
`define ARCADE_STATUS_W 32

// one joystick byte: right, left, down, up, fire1, fire2 from bit 0
`define ARCADE_JOY_W 8

// clk_32 cycles the game stays in reset after the cause clears
`define ARCADE_RESET_HOLD 16

// PS/2 set 2 prefix bytes
`define ARCADE_KEY_RELEASE 8'hF0
`define ARCADE_KEY_EXTENDED 8'hE0

`endif

// File: hw/arcade_pkg.sv
`default_nettype none

package arcade_pkg;

	// command byte at the start of each SPI frame
	typedef enum logic [7:0] {
		op_buttons = 8'h01, // board buttons 1:0, switches 3:2
		op_joy0    = 8'h02,
		op_joy1    = 8'h03,
		op_key     = 8'h05, // PS/2 scancode bytes
		op_status  = 8'h1E  // four bytes, LSB first
	} host_op_e;

	typedef enum logic [1:0] {
		rx_idle,   // deselected
		rx_opcode, // first byte of frame
		rx_data,
		rx_ignore  // wait for deselect
	} rx_state_e;

	// bit positions in the core's button vector
	typedef enum int {
		btn_up    = 0,
		btn_down  = 1,
		btn_left  = 2,
		btn_right = 3,
		btn_fire  = 4,
		btn_bomb  = 5,
		btn_coin  = 6,
		btn_start = 7
	} game_btn_e;

endpackage

`default_nettype wire

// File: hw/host_cmd_rx.sv
`timescale 1ns/100ps
`include "arcade_cfg.svh"
`default_nettype none

module host_cmd_rx
	import arcade_pkg::*;
(
	input  wire                         clk_32,
	input  wire                         arst_n,
	input  wire                         spi_sck,
	input  wire                         spi_mosi,
	input  wire                         spi_ss_io,
	output logic [`ARCADE_STATUS_W-1:0] status,
	output logic [`ARCADE_JOY_W-1:0]    joy0,
	output logic [`ARCADE_JOY_W-1:0]    joy1,
	output logic [1:0]                  board_buttons,
	output logic                        key_strobe,
	output logic                        key_pressed,
	output logic [7:0]                  key_code
);

	logic      sck_meta, sck_sync, sck_prev;
	logic      ss_meta, ss_sync, ss_prev;
	logic      mosi_meta, mosi_sync;
	logic      sck_rise;
	logic      ss_fall;
	logic      byte_done;
	logic [2:0] bit_cnt;
	logic [6:0] shift_q;
	logic [7:0] byte_in;
	logic [1:0] byte_idx; // status byte index
	logic      rel_flag;  // 0xF0 seen
	rx_state_e state;
	host_op_e  op_q;

	// two flops on every pin, third flop on sck/ss for edges
	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n) begin
			sck_meta  <= 1'b0;
			sck_sync  <= 1'b0;
			sck_prev  <= 1'b0;
			ss_meta   <= 1'b0;
			ss_sync   <= 1'b0;
			ss_prev   <= 1'b0;
			mosi_meta <= 1'b0;
			mosi_sync <= 1'b0;
		end else begin
			sck_meta  <= spi_sck;
			sck_sync  <= sck_meta;
			sck_prev  <= sck_sync;
			ss_meta   <= spi_ss_io;
			ss_sync   <= ss_meta;
			ss_prev   <= ss_sync;
			mosi_meta <= spi_mosi;
			mosi_sync <= mosi_meta;
		end
	end

	assign sck_rise  = sck_sync & ~sck_prev;
	assign ss_fall   = ss_prev & ~ss_sync;
	assign byte_in   = {shift_q, mosi_sync}; // msb first
	assign byte_done = sck_rise && !ss_sync && bit_cnt == 3'd7;

	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt <= '0;
			shift_q <= '0;
		end else if (ss_sync) begin
			bit_cnt <= '0; // partial byte dropped
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
			shift_q <= byte_in[6:0];
		end
	end

	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n) begin
			state         <= rx_idle;
			op_q          <= host_op_e'(8'h00);
			byte_idx      <= '0;
			rel_flag      <= 1'b0;
			status        <= '0;
			joy0          <= '0;
			joy1          <= '0;
			board_buttons <= '0;
			key_strobe    <= 1'b0;
			key_pressed   <= 1'b0;
			key_code      <= '0;
		end else begin
			key_strobe <= 1'b0;
			if (state != rx_idle && ss_sync) begin
				state <= rx_idle; // frame ended
			end else begin
				case (state)
					rx_idle: begin
						if (ss_fall) begin
							state    <= rx_opcode;
							byte_idx <= '0;
							rel_flag <= 1'b0;
						end
					end
					rx_opcode: begin
						if (byte_done) begin
							op_q <= host_op_e'(byte_in);
							case (host_op_e'(byte_in))
								op_buttons, op_joy0, op_joy1, op_key, op_status: state <= rx_data;
								default: state <= rx_ignore; // unknown command
							endcase
						end
					end
					rx_data: begin
						if (byte_done) begin
							case (op_q)
								op_buttons: begin
									board_buttons <= byte_in[1:0]; // switches not used
									state         <= rx_ignore;
								end
								op_joy0: begin
									joy0  <= byte_in;
									state <= rx_ignore;
								end
								op_joy1: begin
									joy1  <= byte_in;
									state <= rx_ignore;
								end
								op_key: begin
									if (byte_in == `ARCADE_KEY_RELEASE) begin
										rel_flag <= 1'b1;
									end else if (byte_in != `ARCADE_KEY_EXTENDED) begin
										key_strobe  <= 1'b1;
										key_pressed <= ~rel_flag;
										key_code    <= byte_in;
										rel_flag    <= 1'b0;
									end
								end
								op_status: begin
									status[{byte_idx, 3'b000} +: 8] <= byte_in;
									byte_idx <= byte_idx + 2'd1;
									if (byte_idx == 2'd3)
										state <= rx_ignore; // word complete
								end
								default: state <= rx_ignore;
							endcase
						end
					end
					rx_ignore: begin
						state <= rx_ignore;
					end
					default: state <= rx_idle;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/key_button_map.sv
`timescale 1ns/100ps
`default_nettype none

module key_button_map
	import arcade_pkg::*;
(
	input  wire        clk_32,
	input  wire        arst_n,
	input  wire        key_strobe,
	input  wire        key_pressed,
	input  wire  [7:0] key_code,
	output logic [7:0] key_buttons
);

	logic [7:0] held_q; // one level per game button

	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n) begin
			held_q <= '0;
		end else if (key_strobe) begin
			case (key_code)
				8'h75: held_q[btn_up]    <= key_pressed; // cursor up
				8'h72: held_q[btn_down]  <= key_pressed; // cursor down
				8'h6B: held_q[btn_left]  <= key_pressed; // cursor left
				8'h74: held_q[btn_right] <= key_pressed; // cursor right
				8'h29: held_q[btn_fire]  <= key_pressed; // space
				8'h11: held_q[btn_bomb]  <= key_pressed; // alt
				8'h76: held_q[btn_coin]  <= key_pressed; // esc
				8'h05: held_q[btn_start] <= key_pressed; // F1
				default: held_q <= held_q;
			endcase
		end
	end

	assign key_buttons = held_q;

endmodule

`default_nettype wire

// File: hw/game_input_pack.sv
`timescale 1ns/100ps
`include "arcade_cfg.svh"
`default_nettype none

module game_input_pack
	import arcade_pkg::*;
(
	input  wire                         clk_32,
	input  wire                         arst_n,
	input  wire  [7:0]                  key_buttons,
	input  wire  [`ARCADE_JOY_W-1:0]    joy0,
	input  wire  [`ARCADE_JOY_W-1:0]    joy1,
	input  wire  [1:0]                  board_buttons,
	input  wire  [`ARCADE_STATUS_W-1:0] status,
	output logic [7:0]                  game_buttons,
	output logic                        game_reset_n
);

	// joystick byte layout
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire1 = 4;
	localparam int joy_fire2 = 5;

	localparam int hold_w = $clog2(`ARCADE_RESET_HOLD + 1);
	localparam logic [hold_w-1:0] hold_end = hold_w'(`ARCADE_RESET_HOLD);

	logic [7:0]        merged;
	logic              rst_cause;
	logic [hold_w-1:0] hold_cnt;

	always_comb begin
		merged            = '0;
		merged[btn_up]    = key_buttons[btn_up] | joy0[joy_up] | joy1[joy_up];
		merged[btn_down]  = key_buttons[btn_down] | joy0[joy_down] | joy1[joy_down];
		merged[btn_left]  = key_buttons[btn_left] | joy0[joy_left] | joy1[joy_left];
		merged[btn_right] = key_buttons[btn_right] | joy0[joy_right] | joy1[joy_right];
		merged[btn_fire]  = key_buttons[btn_fire] | joy0[joy_fire1] | joy1[joy_fire1];
		merged[btn_bomb]  = key_buttons[btn_bomb] | joy0[joy_fire2] | joy1[joy_fire2];
		merged[btn_coin]  = key_buttons[btn_coin]; // keyboard only
		merged[btn_start] = key_buttons[btn_start];
	end

	assign game_buttons = ~merged; // core wants active low

	// status reset, menu reset, board reset button
	assign rst_cause = status[0] | status[6] | board_buttons[1];

	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n) begin
			hold_cnt     <= '0;
			game_reset_n <= 1'b0;
		end else begin
			if (rst_cause)
				hold_cnt <= '0;
			else if (hold_cnt != hold_end)
				hold_cnt <= hold_cnt + hold_w'(1);
			game_reset_n <= !rst_cause && hold_cnt == hold_end;
		end
	end

endmodule

`default_nettype wire

// File: hw/arcade_input_top.sv
`timescale 1ns/100ps
`include "arcade_cfg.svh"
`default_nettype none

module arcade_input_top (
	input  wire        clk_32,
	input  wire        arst_n,
	input  wire        spi_sck,
	input  wire        spi_mosi,
	input  wire        spi_ss_io,
	output logic [7:0] game_buttons,
	output logic [1:0] game_select,
	output logic [1:0] scanlines,
	output logic       blend,
	output logic       game_reset_n
);

	logic [`ARCADE_STATUS_W-1:0] status;
	logic [`ARCADE_JOY_W-1:0]    joy0;
	logic [`ARCADE_JOY_W-1:0]    joy1;
	logic [1:0]                  board_buttons;
	logic                        key_strobe;
	logic                        key_pressed;
	logic [7:0]                  key_code;
	logic [7:0]                  key_buttons;

	host_cmd_rx u_host_cmd_rx (
		.clk_32        (clk_32),
		.arst_n        (arst_n),
		.spi_sck       (spi_sck),
		.spi_mosi      (spi_mosi),
		.spi_ss_io     (spi_ss_io),
		.status        (status),
		.joy0          (joy0),
		.joy1          (joy1),
		.board_buttons (board_buttons),
		.key_strobe    (key_strobe),
		.key_pressed   (key_pressed),
		.key_code      (key_code)
	);

	key_button_map u_key_button_map (
		.clk_32      (clk_32),
		.arst_n      (arst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.key_buttons (key_buttons)
	);

	game_input_pack u_game_input_pack (
		.clk_32        (clk_32),
		.arst_n        (arst_n),
		.key_buttons   (key_buttons),
		.joy0          (joy0),
		.joy1          (joy1),
		.board_buttons (board_buttons),
		.status        (status),
		.game_buttons  (game_buttons),
		.game_reset_n  (game_reset_n)
	);

	// option fields of the status word
	assign game_select = status[2:1]; // rom variant
	assign scanlines   = status[4:3];
	assign blend       = status[5];

endmodule

`default_nettype wire

// File: bench/tb_arcade_input.sv
`timescale 1ns/100ps
`include "arcade_cfg.svh"
`default_nettype none

module tb_arcade_input
	import arcade_pkg::*;
();

	localparam int max_entries = 32;
	localparam int half_clks   = 4; // 160 ns sck half period

	logic       clk_32;
	logic       arst_n;
	logic       spi_sck;
	logic       spi_mosi;
	logic       spi_ss_io;
	logic [7:0] game_buttons;
	logic [1:0] game_select;
	logic [1:0] scanlines;
	logic       blend;
	logic       game_reset_n;

	// stimulus and expected values, one row per frame
	string       tname [max_entries];
	logic [7:0]  top_code [max_entries];
	int          tcount [max_entries];
	int          tcut [max_entries]; // bits of last byte sent, 0 = whole byte
	logic [31:0] tdata [max_entries]; // byte 0 goes out first, from bits 7:0
	logic [7:0]  exp_btn [max_entries];
	int          exp_sel [max_entries];
	int          exp_scan [max_entries];
	int          exp_blend [max_entries];
	int          exp_rst [max_entries];
	int          n_entries;

	arcade_input_top dut0 (
		.clk_32       (clk_32),
		.arst_n       (arst_n),
		.spi_sck      (spi_sck),
		.spi_mosi     (spi_mosi),
		.spi_ss_io    (spi_ss_io),
		.game_buttons (game_buttons),
		.game_select  (game_select),
		.scanlines    (scanlines),
		.blend        (blend),
		.game_reset_n (game_reset_n)
	);

	initial clk_32 = 1'b0;
	always #20 clk_32 = ~clk_32;

	// joystick bits: right, left, down, up, fire1, fire2 from bit 0
	function automatic logic [7:0] expected_buttons(input logic [7:0] keys,
			input logic [7:0] j0, input logic [7:0] j1);
		logic [7:0] m;
		m    = keys;
		m[0] = m[0] | j0[3] | j1[3]; // up
		m[1] = m[1] | j0[2] | j1[2];
		m[2] = m[2] | j0[1] | j1[1];
		m[3] = m[3] | j0[0] | j1[0]; // right
		m[4] = m[4] | j0[4] | j1[4];
		m[5] = m[5] | j0[5] | j1[5];
		return ~m;
	endfunction

	task automatic add_entry(input string name, input logic [7:0] op, input int n,
			input int cut, input logic [31:0] data, input logic [7:0] btn,
			input int sel, input int scan, input int bl, input int rst);
		tname[n_entries]     = name;
		top_code[n_entries]  = op;
		tcount[n_entries]    = n;
		tcut[n_entries]      = cut;
		tdata[n_entries]     = data;
		exp_btn[n_entries]   = btn;
		exp_sel[n_entries]   = sel;
		exp_scan[n_entries]  = scan;
		exp_blend[n_entries] = bl;
		exp_rst[n_entries]   = rst;
		n_entries            = n_entries + 1;
	endtask

	task automatic wait_clks(input int n);
		repeat (n) @(posedge clk_32);
		#2; // drive and sample just after the edge
	endtask

	task automatic check_value(input string test_name, input string signal,
			input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s %s expected %0h actual %0h",
				test_name, signal, expected, actual);
			$display("Test failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic send_bit(input logic b);
		spi_mosi = b;
		wait_clks(half_clks);
		spi_sck = 1'b1;
		wait_clks(half_clks);
		spi_sck = 1'b0;
	endtask

	task automatic send_byte(input logic [7:0] b, input int nbits);
		int k;
		for (k = 7; k > 7 - nbits; k--)
			send_bit(b[k]); // msb first
	endtask

	task automatic spi_frame(input logic [7:0] op, input int n, input int cut,
			input logic [31:0] data);
		int i;
		int bits;
		spi_ss_io = 1'b0;
		wait_clks(half_clks);
		send_byte(op, 8);
		for (i = 0; i < n; i++) begin
			bits = (i == n - 1 && cut > 0) ? cut : 8;
			send_byte(data[8*i +: 8], bits);
		end
		wait_clks(half_clks);
		spi_ss_io = 1'b1; // deselect ends the frame
		wait_clks(half_clks);
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		logic [7:0]  r0;
		logic [7:0]  r1;
		logic [7:0]  r2;
		rnd = $urandom;
		r0  = rnd[7:0];
		rnd = $urandom;
		r1  = rnd[7:0];
		rnd = $urandom;
		r2  = rnd[7:0];
		add_entry("joy0_up_fire", op_joy0, 1, 0, 32'h18, 8'hEE, 0, 0, 0, 1);
		add_entry("joy1_right_bomb", op_joy1, 1, 0, 32'h21, 8'hC6, 0, 0, 0, 1);
		add_entry("joy0_clear", op_joy0, 1, 0, 32'h00, 8'hD7, 0, 0, 0, 1);
		add_entry("joy1_clear", op_joy1, 1, 0, 32'h00, 8'hFF, 0, 0, 0, 1);
		add_entry("key_fire_press", op_key, 1, 0, 32'h29, 8'hEF, 0, 0, 0, 1);
		add_entry("key_fire_release", op_key, 2, 0, 32'h29F0, 8'hFF, 0, 0, 0, 1);
		add_entry("key_ext_up", op_key, 2, 0, 32'h75E0, 8'hFE, 0, 0, 0, 1);
		add_entry("key_unmapped", op_key, 1, 0, 32'h1C, 8'hFE, 0, 0, 0, 1);
		add_entry("key_coin_start", op_key, 2, 0, 32'h0576, 8'h3E, 0, 0, 0, 1);
		add_entry("key_rel_up_coin", op_key, 4, 0, 32'h76F075F0, 8'h7F, 0, 0, 0, 1);
		add_entry("key_rel_start", op_key, 2, 0, 32'h05F0, 8'hFF, 0, 0, 0, 1);
		add_entry("rand_joy0", op_joy0, 1, 0, {24'h0, r0},
			expected_buttons(8'h00, r0, 8'h00), 0, 0, 0, 1);
		add_entry("rand_joy1", op_joy1, 1, 0, {24'h0, r1},
			expected_buttons(8'h00, r0, r1), 0, 0, 0, 1);
		add_entry("rand_joy0_b", op_joy0, 1, 0, {24'h0, r2},
			expected_buttons(8'h00, r2, r1), 0, 0, 0, 1);
		add_entry("joy0_clear_b", op_joy0, 1, 0, 32'h00,
			expected_buttons(8'h00, 8'h00, r1), 0, 0, 0, 1);
		add_entry("joy1_clear_b", op_joy1, 1, 0, 32'h00, 8'hFF, 0, 0, 0, 1);
		add_entry("status_opts_a", op_status, 4, 0, 32'hFF5AA52E, 8'hFF, 3, 1, 1, 1);
		add_entry("status_opts_b", op_status, 4, 0, 32'h14, 8'hFF, 2, 2, 0, 1);
		add_entry("status_menu_reset", op_status, 4, 0, 32'h54, 8'hFF, 2, 2, 0, 0);
		add_entry("status_reset_clear", op_status, 4, 0, 32'h14, 8'hFF, 2, 2, 0, 1);
		add_entry("board_reset", op_buttons, 1, 0, 32'h02, 8'hFF, 2, 2, 0, 0);
		add_entry("board_reset_clear", op_buttons, 1, 0, 32'h00, 8'hFF, 2, 2, 0, 1);
		add_entry("joy0_before_cut", op_joy0, 1, 0, 32'h18, 8'hEE, 2, 2, 0, 1);
		add_entry("unknown_opcode", 8'h7F, 2, 0, 32'h0000, 8'hEE, 2, 2, 0, 1);
		add_entry("cut_mid_byte", op_joy0, 1, 4, 32'h00, 8'hEE, 2, 2, 0, 1);
		add_entry("joy0_after_cut", op_joy0, 1, 0, 32'h00, 8'hFF, 2, 2, 0, 1);
	endtask

	initial begin
		int unsigned seed_dummy;
		int i;
		spi_sck    = 1'b0;
		spi_mosi   = 1'b0;
		spi_ss_io  = 1'b1;
		arst_n     = 1'b0;
		n_entries  = 0;
		seed_dummy = $urandom(35);
		build_table();
		wait_clks(3);
		arst_n = 1'b1;
		check_value("after_reset", "game_buttons", 32'h000000FF, 32'(game_buttons));
		check_value("after_reset", "game_reset_n", 32'h0, 32'(game_reset_n));
		wait_clks(`ARCADE_RESET_HOLD - 1);
		check_value("reset_hold", "game_reset_n", 32'h0, 32'(game_reset_n)); // still held
		wait_clks(9);
		check_value("after_reset", "game_reset_n", 32'h1, 32'(game_reset_n));
		for (i = 0; i < n_entries; i++) begin
			spi_frame(top_code[i], tcount[i], tcut[i], tdata[i]);
			wait_clks(8);
			check_value(tname[i], "game_buttons", 32'(exp_btn[i]), 32'(game_buttons));
			check_value(tname[i], "game_select", exp_sel[i], 32'(game_select));
			check_value(tname[i], "scanlines", exp_scan[i], 32'(scanlines));
			check_value(tname[i], "blend", exp_blend[i], 32'(blend));
			wait_clks(`ARCADE_RESET_HOLD + 8); // reset hold must have run out
			check_value(tname[i], "game_reset_n", exp_rst[i], 32'(game_reset_n));
		end
		$display("Test completed successfully");
		$finish;
	end

	// budget from the frame lengths, twice the nominal run time
	initial begin
		int budget;
		int i;
		@(posedge arst_n);
		budget = 2 * (`ARCADE_RESET_HOLD + 16);
		for (i = 0; i < n_entries; i++)
			budget = budget + 2 * ((1 + tcount[i]) * 16 * half_clks + 40 + `ARCADE_RESET_HOLD);
		repeat (budget) @(posedge clk_32);
		$display("timeout: the run did not finish within %0d clock cycles", budget);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
hw/arcade_pkg.sv
hw/host_cmd_rx.sv
hw/key_button_map.sv
hw/game_input_pack.sv
hw/arcade_input_top.sv
bench/tb_arcade_input.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
TOP        = tb_arcade_input
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
